//--- hdl/pcs_pkg.sv
/*
 * Shared types and constants for the multi-lane 64b/66b transmit PCS.
 * Holds the XGMII word types, the block payload union, sync header and
 * block-type values, and the control characters used by the encoder.
 */
package pcs_pkg;

    typedef logic [63:0] xgmii_data_t;
    typedef logic [7:0]  xgmii_ctrl_t;
    typedef logic [1:0]  sync_hdr_t;
    typedef logic [57:0] scr_state_t;

    localparam sync_hdr_t hdr_data = 2'b01;
    localparam sync_hdr_t hdr_ctrl = 2'b10;

    // Block payload, read as raw data or as a control block
    // Block type sits in payload byte 0, the low bits
    typedef union packed {
        xgmii_data_t data;
        struct packed {
            logic [55:0] codes;
            logic [7:0]  block_type;
        } ctrl;
    } pcs_block_u;

    localparam logic [7:0] blk_type_idle  = 8'h1e;
    localparam logic [7:0] blk_type_start = 8'h78;

    // XGMII control characters
    localparam logic [7:0] xgmii_idle  = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_error = 8'hfe;

    // 7-bit control codes inside a control block
    localparam logic [6:0] pcs_code_idle  = 7'h00;
    localparam logic [6:0] pcs_code_error = 7'h1e;

    localparam scr_state_t scr_seed = '1;

endpackage

//--- hdl/lane_dispatch.sv
/*
 * Round-robin distributor in front of the encoder lanes.
 * Each accepted XGMII word goes to the lane under the pointer, and the
 * pointer then moves on, so consecutive words fill consecutive lanes.
 */
module lane_dispatch #(
    parameter int LANES = 4
) (
    input  logic                 gt_rxusrclk,
    input  logic                 gt_tx_reset,
    input  logic                 in_valid,
    input  pcs_pkg::xgmii_data_t xgmii_txd,
    input  pcs_pkg::xgmii_ctrl_t xgmii_txc,
    input  logic [LANES-1:0]     lane_ready,
    output logic                 in_ready,
    output logic [LANES-1:0]     lane_valid,
    output pcs_pkg::xgmii_data_t lane_txd,
    output pcs_pkg::xgmii_ctrl_t lane_txc
);

    localparam int PTR_W = $clog2(LANES);

    logic [PTR_W-1:0] lane_ptr;

    // Word bus is shared, only the selected lane sees valid
    assign lane_txd = xgmii_txd;
    assign lane_txc = xgmii_txc;

    assign in_ready = lane_ready[lane_ptr];

    always_comb begin
        lane_valid = '0;
        lane_valid[lane_ptr] = in_valid;
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            lane_ptr <= '0;
        end else if (in_valid && in_ready) begin
            if (lane_ptr == PTR_W'(LANES - 1)) begin
                lane_ptr <= '0;
            end else begin
                lane_ptr <= lane_ptr + 1'b1;
            end
        end
    end

endmodule

//--- hdl/block_encoder_lane.sv
/*
 * One transmit lane: encodes an XGMII word into a 66-bit block,
 * scrambles the 64-bit payload with the lane's own scrambler and holds
 * the result until the merger takes it. Holds a single block.
 */
module block_encoder_lane (
    input  logic                 gt_rxusrclk,
    input  logic                 gt_tx_reset,
    input  logic                 lane_valid,
    input  pcs_pkg::xgmii_data_t lane_txd,
    input  pcs_pkg::xgmii_ctrl_t lane_txc,
    input  logic                 blk_ready,
    output logic                 lane_ready,
    output logic                 blk_valid,
    output pcs_pkg::pcs_block_u  blk_data,
    output pcs_pkg::sync_hdr_t   blk_hdr
);

    import pcs_pkg::*;

    pcs_block_u  enc_block;
    sync_hdr_t   enc_hdr;
    xgmii_data_t scr_out;
    scr_state_t  scr_next;
    scr_state_t  scr_state;
    logic        lane_live;
    logic        accept;
    logic        is_data;
    logic        is_idle;
    logic        is_start;

    // Low during reset, so the lane refuses words until it is out of it
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            lane_live <= 1'b0;
        end else begin
            lane_live <= 1'b1;
        end
    end

    // Empty, or the held block leaves this cycle
    assign lane_ready = lane_live && (!blk_valid || blk_ready);
    assign accept     = lane_valid && lane_ready;

    assign is_data  = (lane_txc == 8'h00);
    assign is_idle  = (lane_txc == 8'hff) && (lane_txd == {8{xgmii_idle}});
    assign is_start = (lane_txc == 8'h01) && (lane_txd[7:0] == xgmii_start);

    always_comb begin
        enc_hdr = hdr_ctrl;
        enc_block.data = lane_txd;
        if (is_data) begin
            enc_hdr = hdr_data;
        end else if (is_idle) begin
            enc_block.ctrl.block_type = blk_type_idle;
            enc_block.ctrl.codes = {8{pcs_code_idle}};
        end else if (is_start) begin
            // Bytes 1 to 7 ride along unchanged
            enc_block.ctrl.block_type = blk_type_start;
            enc_block.ctrl.codes = lane_txd[63:8];
        end else begin
            enc_block.ctrl.block_type = blk_type_idle;
            enc_block.ctrl.codes = {8{pcs_code_error}};
        end
    end

    // Self-synchronous scrambler, x^58 + x^39 + 1, bit 0 first
    // State bit 0 holds the newest scrambled bit
    always_comb begin
        scr_next = scr_state;
        for (int i = 0; i < 64; i++) begin
            scr_out[i] = enc_block.data[i] ^ scr_next[38] ^ scr_next[57];
            scr_next = {scr_next[56:0], scr_out[i]};
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            blk_valid <= 1'b0;
            scr_state <= scr_seed;
        end else begin
            if (accept) begin
                blk_valid <= 1'b1;
                scr_state <= scr_next;
            end else if (blk_valid && blk_ready) begin
                blk_valid <= 1'b0;
            end
        end
    end

    // Payload register, header goes out unscrambled
    always_ff @(posedge gt_rxusrclk) begin
        if (accept) begin
            blk_data.data <= scr_out;
            blk_hdr <= enc_hdr;
        end
    end

endmodule

//--- hdl/lane_merge.sv
/*
 * Round-robin collector behind the encoder lanes.
 * Presents the block of the lane under the output pointer, hands
 * out_ready back to that lane only, and moves on after each transfer.
 */
module lane_merge #(
    parameter int LANES = 4
) (
    input  logic                 gt_rxusrclk,
    input  logic                 gt_tx_reset,
    input  logic [LANES-1:0]     blk_valid,
    input  pcs_pkg::pcs_block_u  blk_data [LANES],
    input  pcs_pkg::sync_hdr_t   blk_hdr [LANES],
    input  logic                 out_ready,
    output logic [LANES-1:0]     blk_ready,
    output logic                 out_valid,
    output pcs_pkg::xgmii_data_t serdes_tx_data,
    output pcs_pkg::sync_hdr_t   serdes_tx_hdr
);

    localparam int PTR_W = $clog2(LANES);

    logic [PTR_W-1:0] out_ptr;

    assign out_valid      = blk_valid[out_ptr];
    assign serdes_tx_data = blk_data[out_ptr].data;
    assign serdes_tx_hdr  = blk_hdr[out_ptr];

    always_comb begin
        blk_ready = '0;
        blk_ready[out_ptr] = out_ready;
    end

    // Same lane order as the dispatcher keeps blocks in input order
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            out_ptr <= '0;
        end else if (out_valid && out_ready) begin
            if (out_ptr == PTR_W'(LANES - 1)) begin
                out_ptr <= '0;
            end else begin
                out_ptr <= out_ptr + 1'b1;
            end
        end
    end

endmodule

//--- hdl/pcs_tx_lanes.sv
/*
 * Top level of the multi-lane 64b/66b transmit PCS.
 * XGMII words enter with valid/ready, are spread over LANES encoder
 * lanes and leave as sync header plus scrambled payload in input order.
 */
module pcs_tx_lanes #(
    parameter int LANES = 4
) (
    input  logic                 gt_rxusrclk,
    input  logic                 gt_tx_reset,
    input  pcs_pkg::xgmii_data_t xgmii_txd,
    input  pcs_pkg::xgmii_ctrl_t xgmii_txc,
    input  logic                 in_valid,
    input  logic                 out_ready,
    output logic                 in_ready,
    output pcs_pkg::xgmii_data_t serdes_tx_data,
    output pcs_pkg::sync_hdr_t   serdes_tx_hdr,
    output logic                 out_valid
);

    import pcs_pkg::*;

    logic [LANES-1:0] lane_valid;
    logic [LANES-1:0] lane_ready;
    xgmii_data_t      lane_txd;
    xgmii_ctrl_t      lane_txc;

    logic [LANES-1:0] blk_valid;
    logic [LANES-1:0] blk_ready;
    pcs_block_u       blk_data [LANES];
    sync_hdr_t        blk_hdr [LANES];

    lane_dispatch #(
        .LANES(LANES)
    ) lane_dispatch_i (
        .gt_rxusrclk(gt_rxusrclk),
        .gt_tx_reset(gt_tx_reset),
        .in_valid   (in_valid),
        .xgmii_txd  (xgmii_txd),
        .xgmii_txc  (xgmii_txc),
        .lane_ready (lane_ready),
        .in_ready   (in_ready),
        .lane_valid (lane_valid),
        .lane_txd   (lane_txd),
        .lane_txc   (lane_txc)
    );

    for (genvar n = 0; n < LANES; n++) begin : g_lane
        block_encoder_lane block_encoder_lane_i (
            .gt_rxusrclk(gt_rxusrclk),
            .gt_tx_reset(gt_tx_reset),
            .lane_valid (lane_valid[n]),
            .lane_txd   (lane_txd),
            .lane_txc   (lane_txc),
            .blk_ready  (blk_ready[n]),
            .lane_ready (lane_ready[n]),
            .blk_valid  (blk_valid[n]),
            .blk_data   (blk_data[n]),
            .blk_hdr    (blk_hdr[n])
        );
    end

    lane_merge #(
        .LANES(LANES)
    ) lane_merge_i (
        .gt_rxusrclk   (gt_rxusrclk),
        .gt_tx_reset   (gt_tx_reset),
        .blk_valid     (blk_valid),
        .blk_data      (blk_data),
        .blk_hdr       (blk_hdr),
        .out_ready     (out_ready),
        .blk_ready     (blk_ready),
        .out_valid     (out_valid),
        .serdes_tx_data(serdes_tx_data),
        .serdes_tx_hdr (serdes_tx_hdr)
    );

endmodule

//--- verification/pcs_tx_assertions.sv
/*
 * Protocol checks on the transmit PCS ports, bound into pcs_tx_lanes.
 * Output blocks hold under back-pressure, headers stay legal and both
 * handshakes stay low during reset.
 */
module pcs_tx_assertions (
    input logic                 gt_rxusrclk,
    input logic                 gt_tx_reset,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input pcs_pkg::xgmii_data_t serdes_tx_data,
    input pcs_pkg::sync_hdr_t   serdes_tx_hdr
);

    timeunit 1ns;
    timeprecision 1ps;

    import pcs_pkg::*;

    // A presented block waits, unchanged, until it is taken
    hold_until_taken: assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        out_valid && !out_ready |=> out_valid && $stable(serdes_tx_data) &&
            $stable(serdes_tx_hdr)
    ) else $error("Output block changed or vanished before out_ready");

    legal_header: assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        out_valid |-> (serdes_tx_hdr == hdr_data || serdes_tx_hdr == hdr_ctrl)
    ) else $error("Sync header is neither 01 nor 10");

    // First reset edge skipped while the registers settle
    quiet_in_reset: assert property (@(posedge gt_rxusrclk)
        gt_tx_reset && $past(gt_tx_reset) |-> !in_ready && !out_valid
    ) else $error("Handshake active during reset");

endmodule

bind pcs_tx_lanes pcs_tx_assertions pcs_tx_assertions_i (.*);

//--- verification/tb_pcs_tx_lanes.sv
/*
 * Testbench for the multi-lane 64b/66b transmit PCS.
 * Drives XGMII words on the falling edge, predicts each block with a
 * per-lane reference encoder and scrambler, and checks the output stream.
 */
module tb_pcs_tx_lanes;

    timeunit 1ns;
    timeprecision 1ps;

    import pcs_pkg::*;

    localparam int          LANES      = 4;
    localparam int          CLK_PERIOD = 10;
    localparam logic [31:0] SEED       = 32'h17e2_9ef6;
    localparam int          N_DATA     = 64;
    localparam int          N_CTRL     = 32;
    localparam int          N_ERR      = 32;
    localparam int          N_MIX      = 200;
    localparam int          N_WORDS    = N_DATA + N_CTRL + N_ERR + N_MIX;
    localparam int          DRAIN_MAX  = 20 * LANES;

    logic        gt_rxusrclk;
    logic        gt_tx_reset;
    xgmii_data_t xgmii_txd;
    xgmii_ctrl_t xgmii_txc;
    logic        in_valid;
    logic        out_ready;
    logic        in_ready;
    xgmii_data_t serdes_tx_data;
    sync_hdr_t   serdes_tx_hdr;
    logic        out_valid;

    // Model state with one scrambler per lane in dispatch order
    scr_state_t  ref_state [LANES];
    int          ref_lane;
    sync_hdr_t   exp_hdr_q [$];
    xgmii_data_t exp_blk_q [$];
    sync_hdr_t   next_hdr;
    xgmii_data_t next_blk;

    string test_name;
    logic  bp_on;
    int    checks;
    int    errors;
    int    err_start;
    int    tests_run;
    int    tests_bad;

    pcs_tx_lanes #(.LANES(LANES)) pcs_tx_lanes_i (.*);

    initial begin
        gt_rxusrclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) gt_rxusrclk = ~gt_rxusrclk;
        end
    end

    // Generous bound of 20 cycles per word
    initial begin
        #(20 * N_WORDS * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d ns", 20 * N_WORDS * CLK_PERIOD);
        $display("TESTS FAILED");
        $finish;
    end

    // Expected block for one word, advancing that lane's scrambler state
    function automatic void encode_ref(input xgmii_data_t txd, input xgmii_ctrl_t txc,
                                       inout scr_state_t st, output sync_hdr_t hdr,
                                       output xgmii_data_t blk);
        xgmii_data_t payload;
        logic        all_idle;
        logic        bit_out;

        all_idle = 1'b1;
        for (int b = 0; b < 8; b++) begin
            if (txd[8*b +: 8] != 8'h07)
                all_idle = 1'b0;
        end
        hdr = 2'b10;
        payload = {56'h0, 8'h1e};
        if (txc == 8'h00) begin
            hdr = 2'b01;
            payload = txd;
        end else if (txc == 8'h01 && txd[7:0] == 8'hfb) begin
            payload = {txd[63:8], 8'h78};
        end else if (!(txc == 8'hff && all_idle)) begin
            for (int c = 0; c < 8; c++)
                payload[8 + 7*c +: 7] = 7'h1e;
        end
        // Bit 0 goes first and each scrambled bit is shifted into the state
        for (int i = 0; i < 64; i++) begin
            bit_out = payload[i] ^ st[38] ^ st[57];
            st = {st[56:0], bit_out};
            blk[i] = bit_out;
        end
    endfunction

    task automatic compare_hdr(input sync_hdr_t exp, input sync_hdr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: header expected %b, actual %b", test_name, exp, act);
        end
    endtask

    task automatic compare_block(input xgmii_data_t exp, input xgmii_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: block expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // Predict a block for every accepted word
    always @(posedge gt_rxusrclk) begin
        if (!gt_tx_reset && in_valid && in_ready) begin
            encode_ref(xgmii_txd, xgmii_txc, ref_state[ref_lane], next_hdr, next_blk);
            exp_hdr_q.push_back(next_hdr);
            exp_blk_q.push_back(next_blk);
            ref_lane = (ref_lane == LANES - 1) ? 0 : ref_lane + 1;
        end
    end

    always @(posedge gt_rxusrclk) begin
        if (!gt_tx_reset && out_valid && out_ready) begin
            if (exp_blk_q.size() == 0) begin
                errors++;
                $display("Test %s: a block left the DUT with no word sent for it", test_name);
            end else begin
                compare_hdr(exp_hdr_q.pop_front(), serdes_tx_hdr);
                compare_block(exp_blk_q.pop_front(), serdes_tx_data);
            end
        end
    end

    always @(negedge gt_rxusrclk) begin
        out_ready = bp_on ? (($urandom % 2) == 0) : 1'b1;
    end

    task automatic send_word(input xgmii_data_t d, input xgmii_ctrl_t c, input int gap);
        repeat (gap) begin
            @(negedge gt_rxusrclk);
            in_valid = 1'b0;
        end
        @(negedge gt_rxusrclk);
        xgmii_txd = d;
        xgmii_txc = c;
        in_valid  = 1'b1;
        @(posedge gt_rxusrclk);
        while (!in_ready)
            @(posedge gt_rxusrclk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    // Drain the pipeline within a bound and allow a few cycles for stray blocks
    task automatic finish_test();
        int waited;

        @(negedge gt_rxusrclk);
        in_valid = 1'b0;
        waited = 0;
        while (exp_blk_q.size() != 0 && waited < DRAIN_MAX) begin
            @(posedge gt_rxusrclk);
            waited++;
        end
        repeat (2 * LANES) @(posedge gt_rxusrclk);
        tests_run++;
        if (errors != err_start)
            tests_bad++;
        $display("Test %-12s done, %0d errors", test_name, errors - err_start);
    endtask

    initial begin
        xgmii_data_t d;
        xgmii_ctrl_t c;

        void'($urandom(SEED));
        gt_tx_reset = 1'b1;
        in_valid    = 1'b0;
        xgmii_txd   = '0;
        xgmii_txc   = '0;
        out_ready   = 1'b1;
        bp_on       = 1'b0;
        checks      = 0;
        errors      = 0;
        tests_run   = 0;
        tests_bad   = 0;
        ref_lane    = 0;
        for (int n = 0; n < LANES; n++)
            ref_state[n] = scr_seed;

        start_test("reset");
        repeat (8) begin
            @(negedge gt_rxusrclk);
            compare_flag("out_valid in reset", 1'b0, out_valid);
            compare_flag("in_ready in reset", 1'b0, in_ready);
        end
        gt_tx_reset = 1'b0;
        @(negedge gt_rxusrclk);
        compare_flag("out_valid after reset", 1'b0, out_valid);
        compare_flag("in_ready after reset", 1'b1, in_ready);
        finish_test();

        start_test("data");
        repeat (N_DATA)
            send_word({$urandom, $urandom}, 8'h00, 0);
        finish_test();

        start_test("idle_start");
        for (int n = 0; n < N_CTRL; n++) begin
            d = {$urandom, $urandom};
            d[7:0] = 8'hfb;
            if (n % 2 == 0)
                send_word({8{8'h07}}, 8'hff, 0);
            else
                send_word(d, 8'h01, 0);
        end
        finish_test();

        // Near misses of the idle and start patterns are included
        start_test("error");
        repeat (N_ERR) begin
            do begin
                d = {$urandom, $urandom};
                case ($urandom % 4)
                    0: begin
                        c = 8'hff;
                        d = {8{8'h07}};
                        d[8*($urandom % 8) +: 8] = 8'($urandom);
                    end
                    1: c = 8'h01;
                    default: c = 8'($urandom);
                endcase
            end while (c == 8'h00 || (c == 8'h01 && d[7:0] == 8'hfb) ||
                       (c == 8'hff && d == {8{8'h07}}));
            send_word(d, c, $urandom % 2);
        end
        finish_test();

        start_test("backpressure");
        bp_on = 1'b1;
        repeat (N_MIX) begin
            d = {$urandom, $urandom};
            case ($urandom % 4)
                0: c = 8'h00;
                1: begin
                    c = 8'hff;
                    d = {8{8'h07}};
                end
                2: begin
                    c = 8'h01;
                    d[7:0] = 8'hfb;
                end
                default: c = 8'($urandom);
            endcase
            send_word(d, c, (($urandom % 4) == 0) ? ($urandom % 3) + 1 : 0);
        end
        finish_test();
        bp_on = 1'b0;

        if (exp_blk_q.size() != 0) begin
            errors++;
            $display("%0d expected blocks never came out of the DUT", exp_blk_q.size());
        end
        $display("Tests run: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/pcs_pkg.sv
hdl/lane_dispatch.sv
hdl/block_encoder_lane.sv
hdl/lane_merge.sv
hdl/pcs_tx_lanes.sv
verification/pcs_tx_assertions.sv
verification/tb_pcs_tx_lanes.sv

//--- Bender.yml
package:
  name: pcs_tx_lanes

sources:
  - files:
      - hdl/pcs_pkg.sv
      - hdl/lane_dispatch.sv
      - hdl/block_encoder_lane.sv
      - hdl/lane_merge.sv
      - hdl/pcs_tx_lanes.sv
  - target: test
    files:
      - verification/pcs_tx_assertions.sv
      - verification/tb_pcs_tx_lanes.sv
